//--- rdc_geom_pkg.sv
// Block geometry for the RD cost unit
// Block sizes, beats per block, lanes per beat and the QP range

package rdc_geom_pkg;

  // Samples carried by one beat
  localparam int LANES = 32;
  // Lanes summed into one distortion group
  localparam int GROUP = 4;

  typedef enum logic {
    SIZE_8X8   = 1'b0,
    SIZE_16X16 = 1'b1
  } blk_size_t;

  localparam int BEATS_8X8   = 2;
  localparam int BEATS_16X16 = 8;

  // Highest QP with its own table row
  localparam int QP_MAX = 51;

  typedef logic [2:0] beat_cnt_t;
  typedef logic [5:0] qp_t;
  typedef logic [7:0] pos_t;

endpackage

//--- rdc_data_pkg.sv
// Datapath words of the RD cost unit
// Pixel, coefficient, line-sum and cost widths plus the beat tag

package rdc_data_pkg;

  import rdc_geom_pkg::*;

  typedef logic        [7:0]  pix_t;
  typedef logic signed [15:0] coe_t;
  typedef logic        [21:0] sse_line_t;
  typedef logic        [26:0] sse_acc_t;
  typedef logic        [19:0] rate_line_t;
  typedef logic        [11:0] lambda_t;
  // All cost arithmetic wraps at this width
  typedef logic        [23:0] cost_t;

  // Travels with every beat through the pipeline
  typedef struct packed {
    logic      first;
    logic      last;
    blk_size_t size;
    pos_t      pos;
    lambda_t   a;
    lambda_t   b;
  } beat_tag_t;

  typedef struct packed {
    cost_t     cost;
    blk_size_t size;
    pos_t      pos;
  } cost_res_t;

endpackage

//--- rdc_block_sequencer.sv
// Input stage of the RD cost unit
// Counts beats per block, tags first and last beat, holds the block header
// and looks up the rate factors a and b from the QP

`timescale 1ns/1ps

module rdc_block_sequencer
  import rdc_geom_pkg::*;
  import rdc_data_pkg::*;
#(
  parameter int LANES = rdc_geom_pkg::LANES
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             dat_val_i,
  input  blk_size_t        size_i,
  input  qp_t              qp_i,
  input  pos_t             pos_i,
  input  pix_t [LANES-1:0] ori_i,
  input  pix_t [LANES-1:0] rec_i,
  input  coe_t [LANES-1:0] coe_i,
  output logic             beat_val_o,
  output beat_tag_t        tag_o,
  output pix_t [LANES-1:0] ori_o,
  output pix_t [LANES-1:0] rec_o,
  output coe_t [LANES-1:0] coe_o
);

  // Rate slope a and offset b, indexed by QP
  localparam lambda_t A_TAB [QP_MAX+1] = '{
    1, 1, 1, 1, 1, 1, 1, 1,
    1, 1, 1, 1, 1, 1, 1, 1,
    1, 1, 1, 1, 1, 1, 2, 2,
    2, 3, 4, 5, 6, 8, 10, 13,
    17, 21, 28, 36, 47, 61, 78, 100,
    130, 167, 216, 279, 358, 461, 593, 762,
    980, 1260, 1618, 2078};
  localparam lambda_t B_TAB [QP_MAX+1] = '{
    1, 1, 1, 1, 2, 2, 2, 2,
    3, 3, 4, 4, 5, 5, 6, 7,
    8, 9, 11, 13, 15, 17, 19, 22,
    25, 29, 33, 38, 43, 49, 56, 62,
    70, 78, 86, 93, 100, 105, 108, 107,
    101, 87, 62, 22, 1, 1, 1, 1,
    1, 1, 1, 1};

  beat_cnt_t beat_cnt;
  blk_size_t size_r;
  pos_t      pos_r;
  lambda_t   a_r;
  lambda_t   b_r;
  lambda_t   a_w;
  lambda_t   b_w;
  logic      first_w;
  beat_tag_t tag_w;

  assign first_w = (beat_cnt == '0);

  always_comb begin
    if (qp_i > QP_MAX) begin
      a_w = lambda_t'(1);
      b_w = lambda_t'(1);
    end else begin
      a_w = A_TAB[qp_i];
      b_w = B_TAB[qp_i];
    end
  end

  // Header comes straight from the inputs on the first beat
  always_comb begin
    tag_w.first = first_w;
    tag_w.size  = first_w ? size_i : size_r;
    tag_w.pos   = first_w ? pos_i : pos_r;
    tag_w.a     = first_w ? a_w : a_r;
    tag_w.b     = first_w ? b_w : b_r;
    tag_w.last  = (tag_w.size == SIZE_16X16) ?
                  (beat_cnt == beat_cnt_t'(BEATS_16X16 - 1)) :
                  (beat_cnt == beat_cnt_t'(BEATS_8X8 - 1));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt   <= '0;
      size_r     <= SIZE_8X8;
      beat_val_o <= 1'b0;
    end else begin
      beat_val_o <= dat_val_i;
      if (dat_val_i) begin
        beat_cnt <= tag_w.last ? beat_cnt_t'(0) : beat_cnt + 1'b1;
        size_r   <= tag_w.size;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dat_val_i) begin
      pos_r <= tag_w.pos;
      a_r   <= tag_w.a;
      b_r   <= tag_w.b;
      tag_o <= tag_w;
      ori_o <= ori_i;
      rec_o <= rec_i;
      coe_o <= coe_i;
    end
  end

endmodule

//--- rdc_distortion.sv
// Approximate squared error of one beat
// Stage 1 sums absolute differences per lane group, stage 2 adds g*(g>>2)

`timescale 1ns/1ps

module rdc_distortion
  import rdc_geom_pkg::*;
  import rdc_data_pkg::*;
#(
  parameter int LANES = rdc_geom_pkg::LANES
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             beat_val_i,
  input  beat_tag_t        tag_i,
  input  pix_t [LANES-1:0] ori_i,
  input  pix_t [LANES-1:0] rec_i,
  output logic             line_val_o,
  output beat_tag_t        tag_o,
  output sse_line_t        sse_line_o
);

  localparam int NG = LANES / GROUP;
  localparam int GW = $bits(pix_t) + $clog2(GROUP);

  logic [GW-1:0] grp_w [NG];
  logic [GW-1:0] grp_r [NG];
  logic          val_r;
  beat_tag_t     tag_r;
  sse_line_t     sse_w;

  function automatic pix_t abs_diff(pix_t o, pix_t r);
    return (o >= r) ? pix_t'(o - r) : pix_t'(r - o);
  endfunction

  always_comb begin
    for (int k = 0; k < NG; k++) begin
      grp_w[k] = '0;
      for (int j = 0; j < GROUP; j++) begin
        grp_w[k] = grp_w[k] + abs_diff(ori_i[k*GROUP+j], rec_i[k*GROUP+j]);
      end
    end
  end

  // Square approximated as g times a quarter of g
  always_comb begin
    sse_w = '0;
    for (int k = 0; k < NG; k++) begin
      sse_w = sse_w + grp_r[k] * grp_r[k][GW-1:2];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_r      <= 1'b0;
      line_val_o <= 1'b0;
    end else begin
      val_r      <= beat_val_i;
      line_val_o <= val_r;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_val_i) begin
      grp_r <= grp_w;
      tag_r <= tag_i;
    end
    if (val_r) begin
      sse_line_o <= sse_w;
      tag_o      <= tag_r;
    end
  end

endmodule

//--- rdc_rate.sv
// Bitrate estimate of one beat
// Stage 1 sums absolute coefficients per group, stage 2 scales the total by a

`timescale 1ns/1ps

module rdc_rate
  import rdc_geom_pkg::*;
  import rdc_data_pkg::*;
#(
  parameter int LANES = rdc_geom_pkg::LANES
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             beat_val_i,
  input  beat_tag_t        tag_i,
  input  coe_t [LANES-1:0] coe_i,
  output logic             line_val_o,
  output beat_tag_t        tag_o,
  output cost_t            bit_line_o
);

  localparam int NG = LANES / GROUP;
  localparam int PW = $bits(coe_t) + $clog2(GROUP);

  logic [PW-1:0] part_w [NG];
  logic [PW-1:0] part_r [NG];
  logic          val_r;
  beat_tag_t     tag_r;
  rate_line_t    total_w;

  // Magnitude as unsigned so that -32768 stays exact
  function automatic logic [15:0] abs_coe(coe_t c);
    return c[15] ? 16'(-c) : 16'(c);
  endfunction

  always_comb begin
    for (int k = 0; k < NG; k++) begin
      part_w[k] = '0;
      for (int j = 0; j < GROUP; j++) begin
        part_w[k] = part_w[k] + abs_coe(coe_i[k*GROUP+j]);
      end
    end
  end

  always_comb begin
    total_w = '0;
    for (int k = 0; k < NG; k++) begin
      total_w = total_w + part_r[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_r      <= 1'b0;
      line_val_o <= 1'b0;
    end else begin
      val_r      <= beat_val_i;
      line_val_o <= val_r;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_val_i) begin
      part_r <= part_w;
      tag_r  <= tag_i;
    end
    if (val_r) begin
      bit_line_o <= cost_t'(tag_r.a) * cost_t'(total_w);
      tag_o      <= tag_r;
    end
  end

endmodule

//--- rdc_cost_accum.sv
// Block cost accumulator
// Sums distortion and bitrate over the beats of a block and forms
// (distortion >> 3) + bitrate + b on the last beat

`timescale 1ns/1ps

module rdc_cost_accum
  import rdc_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      line_val_i,
  input  beat_tag_t tag_i,
  input  sse_line_t sse_line_i,
  input  cost_t     bit_line_i,
  output logic      cost_val_o,
  output cost_res_t cost_o
);

  sse_acc_t sse_acc;
  cost_t    bit_acc;
  sse_acc_t sse_sum;
  cost_t    bit_sum;

  // First beat restarts both sums
  always_comb begin
    sse_sum = (tag_i.first ? sse_acc_t'(0) : sse_acc) + sse_line_i;
    bit_sum = (tag_i.first ? cost_t'(0) : bit_acc) + bit_line_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cost_val_o <= 1'b0;
    end else begin
      cost_val_o <= line_val_i && tag_i.last;
    end
  end

  always_ff @(posedge clk) begin
    if (line_val_i) begin
      sse_acc <= sse_sum;
      bit_acc <= bit_sum;
      if (tag_i.last) begin
        cost_o.cost <= sse_sum[26:3] + bit_sum + tag_i.b;
        cost_o.size <= tag_i.size;
        cost_o.pos  <= tag_i.pos;
      end
    end
  end

endmodule

//--- rdc_partition_decider.sv
// Split or merge decision
// Keeps the running cost of the four 8x8 blocks and compares the
// enclosing 16x16 cost against it

`timescale 1ns/1ps

module rdc_partition_decider
  import rdc_geom_pkg::*;
  import rdc_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cost_val_i,
  input  cost_res_t cost_i,
  output logic      cover_valid_o,
  output logic      cover_value_o
);

  cost_t sum_8x8;
  logic  quad_start;
  logic  merge_wins;

  // First 8x8 of a quad in z-order
  assign quad_start = (cost_i.pos[1:0] == 2'b00);
  assign merge_wins = (cost_i.cost <= sum_8x8);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_8x8       <= '0;
      cover_valid_o <= 1'b0;
      cover_value_o <= 1'b0;
    end else begin
      cover_valid_o <= cost_val_i;
      if (cost_val_i) begin
        if (cost_i.size == SIZE_8X8) begin
          sum_8x8       <= quad_start ? cost_i.cost : sum_8x8 + cost_i.cost;
          cover_value_o <= 1'b1;
        end else begin
          cover_value_o <= merge_wins;
        end
      end
    end
  end

endmodule

//--- rdcost_decision.sv
// RD cost decision top level
// Decides whether a 16x16 block replaces its four 8x8 blocks.
// Beat in, cover pulse four cycles after the last beat

`timescale 1ns/1ps

module rdcost_decision
  import rdc_geom_pkg::*;
  import rdc_data_pkg::*;
#(
  parameter int LANES = rdc_geom_pkg::LANES
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             dat_val_i,
  input  blk_size_t        size_i,
  input  qp_t              qp_i,
  input  pos_t             pos_i,
  input  pix_t [LANES-1:0] ori_i,
  input  pix_t [LANES-1:0] rec_i,
  input  coe_t [LANES-1:0] coe_i,
  output logic             cover_valid_o,
  output logic             cover_value_o
);

  // ----------------------------------------------------------
  logic             beat_val;
  beat_tag_t        beat_tag;
  pix_t [LANES-1:0] beat_ori;
  pix_t [LANES-1:0] beat_rec;
  coe_t [LANES-1:0] beat_coe;
  sse_line_t        sse_line;
  logic             line_val;
  beat_tag_t        line_tag;
  cost_t            bit_line;
  logic             cost_val;
  cost_res_t        cost_res;

  rdc_block_sequencer #(.LANES(LANES)) u_block_sequencer (
    .clk(clk), .rst_n(rst_n), .dat_val_i(dat_val_i),
    .size_i(size_i), .qp_i(qp_i), .pos_i(pos_i),
    .ori_i(ori_i), .rec_i(rec_i), .coe_i(coe_i),
    .beat_val_o(beat_val), .tag_o(beat_tag),
    .ori_o(beat_ori), .rec_o(beat_rec), .coe_o(beat_coe)
  );

  // Same latency as the rate unit, whose valid and tag lead downstream
  rdc_distortion #(.LANES(LANES)) u_distortion (
    .clk(clk), .rst_n(rst_n), .beat_val_i(beat_val), .tag_i(beat_tag),
    .ori_i(beat_ori), .rec_i(beat_rec),
    .line_val_o(), .tag_o(), .sse_line_o(sse_line)
  );

  rdc_rate #(.LANES(LANES)) u_rate (
    .clk(clk), .rst_n(rst_n), .beat_val_i(beat_val), .tag_i(beat_tag),
    .coe_i(beat_coe),
    .line_val_o(line_val), .tag_o(line_tag), .bit_line_o(bit_line)
  );

  // ----------------------------------------------------------
  rdc_cost_accum u_cost_accum (
    .clk(clk), .rst_n(rst_n), .line_val_i(line_val), .tag_i(line_tag),
    .sse_line_i(sse_line), .bit_line_i(bit_line),
    .cost_val_o(cost_val), .cost_o(cost_res)
  );

  rdc_partition_decider u_partition_decider (
    .clk(clk), .rst_n(rst_n), .cost_val_i(cost_val), .cost_i(cost_res),
    .cover_valid_o(cover_valid_o), .cover_value_o(cover_value_o)
  );

endmodule

//--- rdc_properties.sv
// Output protocol checks for the RD cost unit
// Bound into the top level, watches the cover decision port

`timescale 1ns/1ps

module rdc_properties (
  input logic clk,
  input logic rst_n,
  input logic cover_valid_i,
  input logic cover_value_i
);

  // Decision is a single-cycle pulse
  a_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) cover_valid_i |=> !cover_valid_i
  ) else $error("cover_valid_o high on two consecutive cycles");

  a_value_known: assert property (
    @(posedge clk) disable iff (!rst_n) cover_valid_i |-> !$isunknown(cover_value_i)
  ) else $error("cover_value_o unknown while cover_valid_o is high");

  a_reset_low: assert property (
    @(posedge clk) !rst_n |-> (!cover_valid_i && !cover_value_i)
  ) else $error("cover outputs not low during reset");

endmodule

bind rdcost_decision rdc_properties u_properties (
  .clk(clk), .rst_n(rst_n),
  .cover_valid_i(cover_valid_o), .cover_value_i(cover_value_o)
);

//--- tb_rdcost_decision.sv
// Directed testbench for the RD cost decision unit
// Drives whole 8x8 and 16x16 blocks, models each block cost and checks
// every cover pulse against the split or merge rule

`timescale 1ns/1ps

module tb_rdcost_decision
  import rdc_geom_pkg::*;
  import rdc_data_pkg::*;
();

  // About 150 beats plus reset and drain cycles, with wide margin
  localparam int MAX_CYCLES = 2000;
  localparam int FILL_ZERO  = 0;
  localparam int FILL_LARGE = 1;
  localparam int FILL_RAND  = 2;

  logic             clk;
  logic             rst_n;
  logic             dat_val_i;
  blk_size_t        size_i;
  qp_t              qp_i;
  pos_t             pos_i;
  pix_t [LANES-1:0] ori_i;
  pix_t [LANES-1:0] rec_i;
  coe_t [LANES-1:0] coe_i;
  logic             cover_valid_o;
  logic             cover_value_o;

  pix_t [LANES-1:0] ori_mem [BEATS_16X16];
  pix_t [LANES-1:0] rec_mem [BEATS_16X16];
  coe_t [LANES-1:0] coe_mem [BEATS_16X16];

  int        seed;
  int        cycle_cnt = 0;
  int        pulse_cnt = 0;
  int        exp_pulses = 0;
  cost_t     ref_sum_8x8 = '0;
  blk_size_t exp_size_q [$];
  cost_t     exp_cost_q [$];
  cost_t     exp_sum_q [$];
  blk_size_t mon_size;
  cost_t     mon_cost;
  cost_t     mon_sum;

  rdcost_decision #(.LANES(LANES)) u_rdcost_decision (
    .clk(clk), .rst_n(rst_n), .dat_val_i(dat_val_i),
    .size_i(size_i), .qp_i(qp_i), .pos_i(pos_i),
    .ori_i(ori_i), .rec_i(rec_i), .coe_i(coe_i),
    .cover_valid_o(cover_valid_o), .cover_value_o(cover_value_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    abort_run("Timeout: the run exceeded its cycle limit");
  end

  // ----------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_cover(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic check_cost_rel(input cost_t cost_16, input cost_t sum_8, input logic got);
    logic exp;
    exp = (cost_16 <= sum_8);
    if (got !== exp) begin
      abort_run($sformatf("ERR cover_value_o exp=%h got=%h cost16=%h sum8x8=%h",
                          exp, got, cost_16, sum_8));
    end
  endtask

  // Rows of the rate table used by the tests
  task automatic lookup_ab(input qp_t qp, output lambda_t a, output lambda_t b);
    a = 12'd1;
    b = 12'd1;
    if (qp < 6'd52) begin
      case (qp)
        6'd22: begin
          a = 12'd2;
          b = 12'd19;
        end
        6'd32: begin
          a = 12'd17;
          b = 12'd70;
        end
        6'd37: begin
          a = 12'd61;
          b = 12'd105;
        end
        default: abort_run("QP has no row in the testbench rate table");
      endcase
    end
  endtask

  // Reference cost of the block held in the beat memories
  function automatic cost_t block_cost(input int nbeats, input lambda_t a, input lambda_t b);
    longint sse_tot;
    longint bit_tot;
    int     g;
    int     mag;
    int     coe_sum;
    coe_t   c;
    sse_tot = 0;
    bit_tot = 0;
    for (int i = 0; i < nbeats; i++) begin
      coe_sum = 0;
      for (int k = 0; k < LANES / GROUP; k++) begin
        g = 0;
        for (int j = 0; j < GROUP; j++) begin
          mag = int'(ori_mem[i][k*GROUP+j]) - int'(rec_mem[i][k*GROUP+j]);
          g += (mag < 0) ? -mag : mag;
        end
        sse_tot += g * (g >> 2);
      end
      for (int l = 0; l < LANES; l++) begin
        c = coe_mem[i][l];
        mag = int'(c);
        coe_sum += (mag < 0) ? -mag : mag;
      end
      bit_tot += longint'(a) * coe_sum;
    end
    return cost_t'((sse_tot >> 3) + bit_tot + longint'(b));
  endfunction

  task automatic fill_block(input int mode, input int nbeats);
    for (int i = 0; i < nbeats; i++) begin
      for (int l = 0; l < LANES; l++) begin
        ori_mem[i][l] = pix_t'($random(seed));
        coe_mem[i][l] = '0;
        case (mode)
          FILL_ZERO:  rec_mem[i][l] = ori_mem[i][l];
          FILL_LARGE: rec_mem[i][l] = ~ori_mem[i][l];
          default: begin
            rec_mem[i][l] = pix_t'($random(seed));
            coe_mem[i][l] = coe_t'($random(seed) % 256);
          end
        endcase
      end
    end
  endtask

  task automatic send_block(input blk_size_t size, input qp_t qp, input pos_t pos,
                            input bit gaps);
    int      nbeats;
    lambda_t a;
    lambda_t b;
    cost_t   cost;
    nbeats = (size == SIZE_16X16) ? BEATS_16X16 : BEATS_8X8;
    lookup_ab(qp, a, b);
    cost = block_cost(nbeats, a, b);
    if (size == SIZE_8X8) begin
      ref_sum_8x8 = (pos[1:0] == 2'b00) ? cost : cost_t'(ref_sum_8x8 + cost);
    end
    exp_size_q.push_back(size);
    exp_cost_q.push_back(cost);
    exp_sum_q.push_back(ref_sum_8x8);
    exp_pulses++;
    for (int i = 0; i < nbeats; i++) begin
      @(negedge clk);
      dat_val_i = 1'b1;
      // Junk header on later beats since only the first one is sampled
      size_i = (i == 0) ? size : blk_size_t'(~size);
      qp_i   = (i == 0) ? qp : qp_t'($random(seed));
      pos_i  = (i == 0) ? pos : pos_t'($random(seed));
      ori_i  = ori_mem[i];
      rec_i  = rec_mem[i];
      coe_i  = coe_mem[i];
      if (gaps && i != nbeats - 1) begin
        @(negedge clk);
        dat_val_i = 1'b0;
      end
    end
  endtask

  task automatic run_quad(input int fill_8, input int fill_16, input qp_t qp,
                          input pos_t base, input bit gaps);
    for (int p = 0; p < 4; p++) begin
      fill_block(fill_8, BEATS_8X8);
      send_block(SIZE_8X8, qp, pos_t'(base + p), gaps);
    end
    fill_block(fill_16, BEATS_16X16);
    send_block(SIZE_16X16, qp, base, gaps);
  endtask

  task automatic drain_pulses();
    @(negedge clk);
    dat_val_i = 1'b0;
    // Last pulse shows on the fifth falling edge after the last beat
    repeat (6) @(negedge clk);
    if (pulse_cnt != exp_pulses) begin
      abort_run($sformatf("Expected %0d cover pulses but counted %0d", exp_pulses, pulse_cnt));
    end
  endtask

  // Pops one expectation per cover pulse
  always @(negedge clk) begin
    if (rst_n && cover_valid_o) begin
      if (exp_size_q.size() == 0) begin
        abort_run("cover_valid_o pulsed with no block outstanding");
      end else begin
        mon_size = exp_size_q.pop_front();
        mon_cost = exp_cost_q.pop_front();
        mon_sum  = exp_sum_q.pop_front();
        pulse_cnt++;
        if (mon_size == SIZE_8X8) begin
          check_cover("cover_value_o", 1'b1, cover_value_o);
        end else begin
          check_cost_rel(mon_cost, mon_sum, cover_value_o);
        end
      end
    end
  end

  // ----------------------------------------------------------
  task automatic test_latency_reset();
    check_cover("cover_valid_o", 1'b0, cover_valid_o);
    check_cover("cover_value_o", 1'b0, cover_value_o);
    fill_block(FILL_RAND, BEATS_8X8);
    send_block(SIZE_8X8, 6'd22, 8'd0, 1'b0);
    // Pulse lands 4 edges after the last beat is sampled
    for (int i = 1; i <= 5; i++) begin
      @(negedge clk);
      dat_val_i = 1'b0;
      check_cover("cover_valid_o", i == 5, cover_valid_o);
    end
    drain_pulses();
  endtask

  task automatic test_cover_wins();
    run_quad(FILL_LARGE, FILL_ZERO, 6'd32, 8'd0, 1'b0);
    drain_pulses();
    check_cover("cover_value_o", 1'b1, cover_value_o);
  endtask

  task automatic test_split_wins();
    run_quad(FILL_ZERO, FILL_LARGE, 6'd32, 8'd0, 1'b0);
    drain_pulses();
    check_cover("cover_value_o", 1'b0, cover_value_o);
  endtask

  task automatic test_qp_scaling();
    int  saved_seed;
    qp_t qp_list [4];
    qp_list = '{6'd22, 6'd32, 6'd37, 6'd60};
    saved_seed = seed;
    foreach (qp_list[q]) begin
      seed = saved_seed;
      run_quad(FILL_RAND, FILL_RAND, qp_list[q], 8'd0, 1'b0);
    end
    drain_pulses();
  endtask

  task automatic test_back_to_back();
    run_quad(FILL_RAND, FILL_RAND, 6'd37, 8'd0, 1'b0);
    run_quad(FILL_RAND, FILL_RAND, 6'd22, 8'd4, 1'b1);
    drain_pulses();
  endtask

  initial begin
    seed      = 75;
    rst_n     = 1'b0;
    dat_val_i = 1'b0;
    size_i    = SIZE_8X8;
    qp_i      = '0;
    pos_i     = '0;
    ori_i     = '0;
    rec_i     = '0;
    coe_i     = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_latency_reset();
    test_cover_wins();
    test_split_wins();
    test_qp_scaling();
    test_back_to_back();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- src.f
rdc_geom_pkg.sv
rdc_data_pkg.sv
rdc_block_sequencer.sv
rdc_distortion.sv
rdc_rate.sv
rdc_cost_accum.sv
rdc_partition_decider.sv
rdcost_decision.sv
rdc_properties.sv
tb_rdcost_decision.sv

//--- run_sim.sh
#!/bin/sh
# Build the RD cost testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_rdcost_decision \
  -f src.f -o sim_rdcost
./obj_dir/sim_rdcost > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
  echo "RD cost run failed, see sim.log"
  exit 1
fi
